// File: sim.f
+incdir+source
source/SandboxPkg.sv
source/UartRx.sv
source/UartTx.sv
source/WideUartIo.sv
source/SandboxProcess.sv
source/Sandbox.sv
tb/SandboxTb.sv

// File: Makefile
# Verilator build and run of the sandbox testbench
# Pass or fail is taken from the simulation log

VERILATOR ?= verilator
TOP       ?= SandboxTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/sandbox_stimulus.txt
# control payload status result, all hex, payload and result byte 0 rightmost
# status = frame count (mod 64) in bits 7:2, op in bits 1:0
00 0123456789ab 00 0123456789ab
01 0123456789ab 05 fedcba987654
02 0123456789ab 0a ab8967452301
03 0123456789ab 0f 0123456789ac
03 0000000000ff 13 000000000100
03 00ffffffffff 17 010000000000
03 ffffffffffff 1b 000000000000
02 112233445566 1e 665544332211
fd 000000000000 21 ffffffffffff
7c a5a5a5a5a5a5 24 a5a5a5a5a5a5
01 a5a5a5a5a5a5 29 5a5a5a5a5a5a
02 000000000001 2e 010000000000
03 7fffffffffff 33 800000000000
00 deadbeef0042 34 deadbeef0042
01 deadbeef0042 39 21524110ffbd
02 deadbeef0042 3e 4200efbeadde
03 deadbeef0042 43 deadbeef0043
01 c0ffee000011 45 3f0011ffffee
02 c0ffee000012 4a 120000eeffc0
03 c0ffee000013 4f c0ffee000014
00 c0ffee000014 50 c0ffee000014
01 c0ffee000015 55 3f0011ffffea
02 c0ffee000016 5a 160000eeffc0
03 c0ffee000017 5f c0ffee000018
00 c0ffee000018 60 c0ffee000018
01 c0ffee000019 65 3f0011ffffe6
02 c0ffee00001a 6a 1a0000eeffc0
03 c0ffee00001b 6f c0ffee00001c
00 c0ffee00001c 70 c0ffee00001c
01 c0ffee00001d 75 3f0011ffffe2
02 c0ffee00001e 7a 1e0000eeffc0
03 c0ffee00001f 7f c0ffee000020
00 c0ffee000020 80 c0ffee000020
01 c0ffee000021 85 3f0011ffffde
02 c0ffee000022 8a 220000eeffc0
03 c0ffee000023 8f c0ffee000024
00 c0ffee000024 90 c0ffee000024
01 c0ffee000025 95 3f0011ffffda
02 c0ffee000026 9a 260000eeffc0
03 c0ffee000027 9f c0ffee000028
00 c0ffee000028 a0 c0ffee000028
01 c0ffee000029 a5 3f0011ffffd6
02 c0ffee00002a aa 2a0000eeffc0
03 c0ffee00002b af c0ffee00002c
00 c0ffee00002c b0 c0ffee00002c
01 c0ffee00002d b5 3f0011ffffd2
02 c0ffee00002e ba 2e0000eeffc0
03 c0ffee00002f bf c0ffee000030
00 c0ffee000030 c0 c0ffee000030
01 c0ffee000031 c5 3f0011ffffce
02 c0ffee000032 ca 320000eeffc0
03 c0ffee000033 cf c0ffee000034
00 c0ffee000034 d0 c0ffee000034
01 c0ffee000035 d5 3f0011ffffca
02 c0ffee000036 da 360000eeffc0
03 c0ffee000037 df c0ffee000038
00 c0ffee000038 e0 c0ffee000038
01 c0ffee000039 e5 3f0011ffffc6
02 c0ffee00003a ea 3a0000eeffc0
03 c0ffee00003b ef c0ffee00003c
00 c0ffee00003c f0 c0ffee00003c
01 c0ffee00003d f5 3f0011ffffc2
02 c0ffee00003e fa 3e0000eeffc0
03 c0ffee00003f ff c0ffee000040
01 0f0f0f0f0f0f 01 f0f0f0f0f0f0
03 00000000ffff 07 000000010000
02 010203040506 0a 060504030201

// File: tb/SandboxTb.sv
// Self-checking testbench of the sandbox top level
// Sends the frames of the stimulus file on rx and checks every reply on tx

`include "sandbox_macros.svh"

module SandboxTb;

  localparam int SCALE       = `SANDBOX_CLOCK_SCALE;
  localparam int WIDTH       = `SANDBOX_WIDTH;
  localparam int FRAME_BYTES = `SANDBOX_WIDTH + 1;
  localparam int MAX_FRAMES  = 256;

  logic masterClock;
  logic rstN;
  logic rx;
  logic tx;
  logic rxIndicator;

  // Frames and expected replies from the stimulus file
  SandboxPkg::controlT controls   [MAX_FRAMES];
  SandboxPkg::payloadT payloads   [MAX_FRAMES];
  SandboxPkg::statusT  expStatus  [MAX_FRAMES];
  SandboxPkg::payloadT expResults [MAX_FRAMES];

  int frameTotal   = 0;
  int repliesDone  = 0;
  int cycleCount   = 0;
  int timeoutLimit = 0;

  Sandbox i_dut (
    .masterClock (masterClock),
    .rstN        (rstN),
    .rx          (rx),
    .tx          (tx),
    .rxIndicator (rxIndicator)
  );

  // --------------------------------------------------
  // Clock and timeout
  // --------------------------------------------------
  initial masterClock = 1'b0;
  always #4 masterClock = ~masterClock;

  always @(posedge masterClock) begin
    cycleCount <= cycleCount + 1;
    if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
      stopOnFailure($sformatf("Timeout: the run did not end within %0d cycles", timeoutLimit));
    end
  end

  // --------------------------------------------------
  // Failure and compare tasks
  // --------------------------------------------------
  task automatic stopOnFailure(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic checkStatus(input int frame, input SandboxPkg::statusT expected,
                             input SandboxPkg::statusT actual);
    if (actual !== expected) begin
      stopOnFailure($sformatf("Fail status of frame %0d: expected 0x%h, actual 0x%h",
                              frame, expected, actual));
    end
  endtask

  task automatic checkPayload(input int frame, input SandboxPkg::payloadT expected,
                              input SandboxPkg::payloadT actual);
    if (actual !== expected) begin
      stopOnFailure($sformatf("Fail result of frame %0d: expected 0x%h, actual 0x%h",
                              frame, expected, actual));
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stopOnFailure($sformatf("Fail %s: expected 0x%h, actual 0x%h", name, expected, actual));
    end
  endtask

  // --------------------------------------------------
  // Stimulus file
  // --------------------------------------------------
  // Columns are control, payload, expected status and expected result
  task automatic readStimulus();
    int          fd;
    int          fields;
    string       line;
    logic [7:0]  ctrlVal;
    logic [47:0] dataVal;
    logic [7:0]  statusVal;
    logic [47:0] resultVal;
    fd = $fopen("tb/sandbox_stimulus.txt", "r");
    if (fd == 0) begin
      stopOnFailure("Could not open the stimulus file tb/sandbox_stimulus.txt");
    end
    while ($fgets(line, fd) > 0) begin
      // Comment and blank lines
      if (line.len() < 8 || line.getc(0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%h %h %h %h", ctrlVal, dataVal, statusVal, resultVal);
      if (fields != 4 || frameTotal >= MAX_FRAMES) begin
        stopOnFailure($sformatf("Stimulus line could not be used: %s", line));
      end
      controls[frameTotal]   = SandboxPkg::controlT'(ctrlVal);
      payloads[frameTotal]   = dataVal;
      expStatus[frameTotal]  = SandboxPkg::statusT'(statusVal);
      expResults[frameTotal] = resultVal;
      frameTotal++;
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------
  // Serial host model
  // --------------------------------------------------
  // Start bit, 8 data bits LSB first, stop bit
  task automatic sendByte(input SandboxPkg::byteT value);
    logic [9:0] bits;
    bits = {1'b1, value, 1'b0};
    for (int b = 0; b < 10; b++) begin
      @(negedge masterClock);
      rx = bits[b];
      repeat (SCALE - 1) @(negedge masterClock);
    end
  endtask

  // Random idle time before each payload byte
  task automatic sendFrame(input int frame);
    int gap;
    sendByte(SandboxPkg::byteT'(controls[frame]));
    for (int j = 0; j < WIDTH; j++) begin
      gap = $urandom % (2 * SCALE + 1);
      repeat (gap) @(negedge masterClock);
      sendByte(payloads[frame][j]);
    end
  endtask

  // Finds the start edge and then samples at bit centers
  task automatic receiveByte(output SandboxPkg::byteT value);
    while (tx !== 1'b0) begin
      @(negedge masterClock);
    end
    repeat (SCALE / 2) @(negedge masterClock);
    if (tx !== 1'b0) begin
      stopOnFailure("The start bit on tx ended before its center");
    end
    for (int b = 0; b < 8; b++) begin
      repeat (SCALE) @(negedge masterClock);
      value[b] = tx;
    end
    repeat (SCALE) @(negedge masterClock);
    if (tx !== 1'b1) begin
      stopOnFailure("A reply byte on tx had a bad stop bit");
    end
  endtask

  // Status byte first and result bytes LSB first
  task automatic receiveReply(input int frame);
    SandboxPkg::byteT    replyBytes [FRAME_BYTES];
    SandboxPkg::statusT  status;
    SandboxPkg::payloadT result;
    for (int j = 0; j < FRAME_BYTES; j++) begin
      receiveByte(replyBytes[j]);
    end
    status = SandboxPkg::statusT'(replyBytes[0]);
    for (int j = 0; j < WIDTH; j++) begin
      result[j] = replyBytes[j + 1];
    end
    checkStatus(frame, expStatus[frame], status);
    checkPayload(frame, expResults[frame], result);
    // Next frame is held back until this reply ends
    checkBit("rxIndicator", ((frame + 1) % 2) == 1, rxIndicator);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    rx   = 1'b1;
    rstN = 1'b0;
    void'($urandom(32'h2f78));
    readStimulus();
    // Twice the serial time of every request and reply
    timeoutLimit = frameTotal * 14 * 10 * SCALE * 2 + 1000;

    repeat (2) @(posedge masterClock);
    @(negedge masterClock);
    rstN = 1'b1;

    // Quiet line after reset
    repeat (20 * SCALE) begin
      @(negedge masterClock);
      checkBit("tx", 1'b1, tx);
      checkBit("rxIndicator", 1'b0, rxIndicator);
    end

    // Frame k may start once reply k-2 is in, so requests overlap replies
    fork
      begin
        for (int k = 0; k < frameTotal; k++) begin
          while (repliesDone < k - 1) begin
            @(negedge masterClock);
          end
          sendFrame(k);
        end
      end
      begin
        for (int k = 0; k < frameTotal; k++) begin
          receiveReply(k);
          repliesDone++;
        end
      end
    join

    // Line idle again and indicator parity of all frames
    repeat (20 * SCALE) begin
      @(negedge masterClock);
      checkBit("tx", 1'b1, tx);
    end
    checkBit("rxIndicator", (frameTotal % 2) == 1, rxIndicator);

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: source/Sandbox.sv
// Top level of the hardware test sandbox on one clock
// Frame level UART on rx and tx, process toggles rxIndicator per frame

`include "sandbox_macros.svh"

module Sandbox (
  input  logic masterClock,
  input  logic rstN,
  input  logic rx,
  output logic tx,
  output logic rxIndicator
);

  // --------------------------------------------------
  // Handshake between interface and process
  // --------------------------------------------------
  SandboxPkg::rxFrameT rxFrame;
  SandboxPkg::txFrameT txFrame;
  logic                dataReceived;
  logic                transmitting;
  logic                clearDR;
  logic                transmit;

  // Host link
  WideUartIo #(.CLOCK_SCALE (`SANDBOX_CLOCK_SCALE),
               .WIDTH       (`SANDBOX_WIDTH))
    dataInterface (.masterClock  (masterClock),
                   .rstN         (rstN),
                   .rx           (rx),
                   .tx           (tx),
                   .txFrame      (txFrame),
                   .transmit     (transmit),
                   .clearDR      (clearDR),
                   .rxFrame      (rxFrame),
                   .dataReceived (dataReceived),
                   .transmitting (transmitting));

  // Operation on each received frame
  SandboxProcess
    sandboxProcess (.masterClock  (masterClock),
                    .rstN         (rstN),
                    .dataReceived (dataReceived),
                    .rxFrame      (rxFrame),
                    .transmitting (transmitting),
                    .clearDR      (clearDR),
                    .transmit     (transmit),
                    .txFrame      (txFrame),
                    .rxIndicator  (rxIndicator));

endmodule

// File: source/SandboxProcess.sv
// Device under test of the sandbox: takes a received frame, applies the chosen
// operation to the payload and orders the reply with a status byte

module SandboxProcess (
  input  logic                 masterClock,
  input  logic                 rstN,
  input  logic                 dataReceived,
  input  SandboxPkg::rxFrameT  rxFrame,
  input  logic                 transmitting,
  output logic                 clearDR,
  output logic                 transmit,
  output SandboxPkg::txFrameT  txFrame,
  output logic                 rxIndicator
);

  localparam int BYTES = $bits(SandboxPkg::payloadT) / 8;

  logic                 accept;
  SandboxPkg::payloadT  result;
  SandboxPkg::payloadT  resultData;
  logic [5:0]           frameCount;
  SandboxPkg::statusT   status;

  // Idle means no request issued on the previous cycle
  // A reply still on the line holds the frame in the interface
  assign accept = dataReceived && !clearDR && !transmitting;

  // --------------------------------------------------
  // Operation on the payload
  // --------------------------------------------------
  always_comb begin
    result = rxFrame.data;
    unique case (rxFrame.control.op)
      SandboxPkg::opEcho: begin
        result = rxFrame.data;
      end
      SandboxPkg::opInvert: begin
        result = ~rxFrame.data;
      end
      SandboxPkg::opReverse: begin
        // Byte 0 swaps with the top byte
        for (int i = 0; i < BYTES; i++) begin
          result[i] = rxFrame.data[BYTES-1-i];
        end
      end
      SandboxPkg::opIncrement: begin
        // Wraps to zero from all ones
        result = SandboxPkg::payloadT'(rxFrame.data + 1'b1);
      end
    endcase
  end

  // --------------------------------------------------
  // Control and status state
  // --------------------------------------------------
  always_ff @(posedge masterClock) begin
    if (!rstN) begin
      clearDR     <= 1'b0;
      transmit    <= 1'b0;
      frameCount  <= '0;
      status      <= '0;
      rxIndicator <= 1'b0;
    end else begin
      clearDR  <= accept;
      transmit <= accept;
      if (accept) begin
        // Reply reports the count before this frame
        status.frameCount <= frameCount;
        status.op         <= rxFrame.control.op;
        frameCount        <= frameCount + 1'b1;
        rxIndicator       <= !rxIndicator;
      end
    end
  end

  always_ff @(posedge masterClock) begin
    if (accept) resultData <= result;
  end

  assign txFrame.status = status;
  assign txFrame.data   = resultData;

  // Clear only a frame that is actually pending in the interface
  aClearPending: assert property (@(posedge masterClock) disable iff (!rstN)
    clearDR |-> dataReceived)
    else $error("clearDR without a pending frame");

endmodule

// File: source/WideUartIo.sv
// Frame level UART: assembles control plus payload bytes into rxFrame and
// serializes status plus result bytes, with the dataReceived and transmitting handshakes

`include "sandbox_macros.svh"

module WideUartIo #(
  parameter int CLOCK_SCALE = `SANDBOX_CLOCK_SCALE,
  parameter int WIDTH       = `SANDBOX_WIDTH
) (
  input  logic                 masterClock,
  input  logic                 rstN,
  input  logic                 rx,
  output logic                 tx,
  input  SandboxPkg::txFrameT  txFrame,
  input  logic                 transmit,
  input  logic                 clearDR,
  output SandboxPkg::rxFrameT  rxFrame,
  output logic                 dataReceived,
  output logic                 transmitting
);

  localparam int INDEX_WIDTH = $clog2(WIDTH + 2);
  localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(WIDTH);
  localparam logic [INDEX_WIDTH-1:0] DONE_INDEX = INDEX_WIDTH'(WIDTH + 1);

  SandboxPkg::byteT               rxByte;
  logic                           rxValid;
  SandboxPkg::byteT               txByte;
  logic                           txStart;
  logic                           txBusy;

  // Byte 0 is the header, bytes 1 to WIDTH the payload
  SandboxPkg::byteT [WIDTH:0]     rxBytes;
  SandboxPkg::byteT [WIDTH:0]     txBytes;
  logic [INDEX_WIDTH-1:0]         rxIndex;
  logic [INDEX_WIDTH-1:0]         txIndex;

  // --------------------------------------------------
  // Receive side
  // --------------------------------------------------
  UartRx #(.CLOCK_SCALE (CLOCK_SCALE))
    receiver (.masterClock (masterClock),
              .rstN        (rstN),
              .rx          (rx),
              .rxByte      (rxByte),
              .rxValid     (rxValid));

  // Flag set on the last byte, held until the process clears it
  // Bytes arriving while it is set are lost
  always_ff @(posedge masterClock) begin
    if (!rstN) begin
      rxIndex      <= '0;
      dataReceived <= 1'b0;
    end else begin
      if (clearDR) dataReceived <= 1'b0;
      if (rxValid && !dataReceived) begin
        if (rxIndex == LAST_INDEX) begin
          rxIndex      <= '0;
          dataReceived <= 1'b1;
        end else begin
          rxIndex <= rxIndex + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge masterClock) begin
    if (rxValid && !dataReceived) rxBytes[rxIndex] <= rxByte;
  end

  assign rxFrame.control = SandboxPkg::controlT'(rxBytes[0]);
  assign rxFrame.data    = rxBytes[WIDTH:1];

  // --------------------------------------------------
  // Transmit side
  // --------------------------------------------------
  // Frame captured on the strobe, process may change txFrame afterwards
  always_ff @(posedge masterClock) begin
    if (transmit) begin
      txBytes[0]       <= txFrame.status;
      txBytes[WIDTH:1] <= txFrame.data;
    end
  end

  // Next byte goes out as soon as the transmitter is free
  assign txStart = transmitting && !txBusy && (txIndex != DONE_INDEX);
  assign txByte  = txBytes[txIndex];

  always_ff @(posedge masterClock) begin
    if (!rstN) begin
      transmitting <= 1'b0;
      txIndex      <= '0;
    end else if (transmit) begin
      transmitting <= 1'b1;
      txIndex      <= '0;
    end else if (transmitting) begin
      if (txStart) begin
        txIndex <= txIndex + 1'b1;
      end else if (!txBusy && txIndex == DONE_INDEX) begin
        // Last stop bit has ended
        transmitting <= 1'b0;
      end
    end
  end

  UartTx #(.CLOCK_SCALE (CLOCK_SCALE))
    transmitter (.masterClock (masterClock),
                 .rstN        (rstN),
                 .txByte      (txByte),
                 .txStart     (txStart),
                 .tx          (tx),
                 .txBusy      (txBusy));

  // A second reply would overwrite txBytes mid frame
  aTransmitIdle: assert property (@(posedge masterClock) disable iff (!rstN)
    transmit |-> !transmitting)
    else $error("transmit strobe while a reply is still going out");

endmodule

// File: source/UartTx.sv
// 8N1 serial transmitter, one byte per txStart strobe
// txBusy stays high from the start bit to the end of the stop bit

`include "sandbox_macros.svh"

module UartTx #(
  parameter int CLOCK_SCALE = `SANDBOX_CLOCK_SCALE
) (
  input  logic               masterClock,
  input  logic               rstN,
  input  SandboxPkg::byteT   txByte,
  input  logic               txStart,
  output logic               tx,
  output logic               txBusy
);

  localparam int TIMER_WIDTH = $clog2(CLOCK_SCALE + 1);
  localparam logic [TIMER_WIDTH-1:0] BIT_LAST = TIMER_WIDTH'(CLOCK_SCALE - 1);

  // Stop bit plus 8 data bits still to go out
  logic [8:0]              txShift;
  logic [TIMER_WIDTH-1:0]  bitTimer;
  logic [3:0]              bitIndex;
  logic                    bitEnd;

  assign bitEnd = (bitTimer == BIT_LAST);

  // --------------------------------------------------
  // Bit timing and line drive
  // --------------------------------------------------
  always_ff @(posedge masterClock) begin
    if (!rstN) begin
      tx       <= 1'b1;
      txBusy   <= 1'b0;
      bitTimer <= '0;
      bitIndex <= '0;
    end else if (txStart && !txBusy) begin
      // Start bit on the next cycle
      tx       <= 1'b0;
      txBusy   <= 1'b1;
      bitTimer <= '0;
      bitIndex <= '0;
    end else if (txBusy) begin
      bitTimer <= bitTimer + 1'b1;
      if (bitEnd) begin
        bitTimer <= '0;
        if (bitIndex == 4'd9) begin
          // Stop bit done, line already high
          txBusy <= 1'b0;
        end else begin
          tx       <= txShift[0];
          bitIndex <= bitIndex + 1'b1;
        end
      end
    end
  end

  // Shift register, loaded with stop bit above the data
  always_ff @(posedge masterClock) begin
    if (txStart && !txBusy) begin
      txShift <= {1'b1, txByte};
    end else if (txBusy && bitEnd) begin
      txShift <= {1'b1, txShift[8:1]};
    end
  end

  // Serializer must wait for the previous stop bit
  aTxStartIdle: assert property (@(posedge masterClock) disable iff (!rstN)
    txStart |-> !txBusy)
    else $error("txStart while the transmitter is busy");

endmodule

// File: source/UartRx.sv
// 8N1 serial receiver, samples each bit at its middle
// Emits a one-cycle rxValid with rxByte, a bad stop bit gives no strobe

`include "sandbox_macros.svh"

module UartRx #(
  parameter int CLOCK_SCALE = `SANDBOX_CLOCK_SCALE
) (
  input  logic               masterClock,
  input  logic               rstN,
  input  logic               rx,
  output SandboxPkg::byteT   rxByte,
  output logic               rxValid
);

  localparam int TIMER_WIDTH = $clog2(CLOCK_SCALE + 1);
  localparam logic [TIMER_WIDTH-1:0] BIT_LAST  = TIMER_WIDTH'(CLOCK_SCALE - 1);
  localparam logic [TIMER_WIDTH-1:0] HALF_LAST = TIMER_WIDTH'(CLOCK_SCALE / 2 - 1);

  typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxStateT;

  rxStateT                 rxState;
  logic                    rxMeta;
  logic                    rxSync;
  logic [TIMER_WIDTH-1:0]  bitTimer;
  logic [2:0]              bitIndex;
  SandboxPkg::byteT        rxShift;
  logic                    bitEnd;

  // Middle of a data or stop bit once centered on the start bit
  assign bitEnd = (bitTimer == BIT_LAST);

  // --------------------------------------------------
  // Synchronizer, idles high like the line
  // --------------------------------------------------
  always_ff @(posedge masterClock) begin
    if (!rstN) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
    end
  end

  // --------------------------------------------------
  // Bit FSM
  // --------------------------------------------------
  always_ff @(posedge masterClock) begin
    if (!rstN) begin
      rxState  <= rxIdle;
      bitTimer <= '0;
      bitIndex <= '0;
      rxValid  <= 1'b0;
    end else begin
      rxValid  <= 1'b0;
      bitTimer <= bitTimer + 1'b1;
      case (rxState)
        rxIdle: begin
          bitTimer <= '0;
          if (!rxSync) rxState <= rxStart;
        end
        rxStart: begin
          // Half a bit in, line must still be low
          if (bitTimer == HALF_LAST) begin
            bitTimer <= '0;
            bitIndex <= '0;
            rxState  <= rxSync ? rxIdle : rxData;
          end
        end
        rxData: begin
          if (bitEnd) begin
            bitTimer <= '0;
            bitIndex <= bitIndex + 1'b1;
            if (bitIndex == 3'd7) rxState <= rxStop;
          end
        end
        rxStop: begin
          if (bitEnd) begin
            bitTimer <= '0;
            rxState  <= rxIdle;
            // Framing error drops the byte
            rxValid  <= rxSync;
          end
        end
        default: rxState <= rxIdle;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge masterClock) begin
    if (rxState == rxData && bitEnd) rxShift <= {rxSync, rxShift[7:1]};
    if (rxState == rxStop && bitEnd) rxByte <= rxShift;
  end

  // Frame assembler counts one byte per strobe
  aRxValidPulse: assert property (@(posedge masterClock) disable iff (!rstN)
    rxValid |=> !rxValid)
    else $error("rxValid held for more than one cycle");

endmodule

// File: source/SandboxPkg.sv
// Shared types of the sandbox: bytes, payload, control and status bytes, frames
// Referenced by scoped names from the interface, the process and the testbench

`include "sandbox_macros.svh"

package SandboxPkg;

  // --------------------------------------------------
  // Basic units
  // --------------------------------------------------
  typedef logic [7:0] byteT;

  // Byte 0 sits in the least significant position
  typedef byteT [`SANDBOX_WIDTH-1:0] payloadT;

  // Operation applied to the payload
  typedef enum logic [1:0] {
    opEcho      = 2'd0,
    opInvert    = 2'd1,
    opReverse   = 2'd2,
    opIncrement = 2'd3
  } opT;

  // --------------------------------------------------
  // Header bytes
  // --------------------------------------------------
  // First byte of a request
  typedef struct packed {
    logic [5:0] reserved;
    opT         op;
  } controlT;

  // First byte of a reply, counter wraps at 64
  typedef struct packed {
    logic [5:0] frameCount;
    opT         op;
  } statusT;

  // --------------------------------------------------
  // Whole frames
  // --------------------------------------------------
  typedef struct packed {
    controlT control;
    payloadT data;
  } rxFrameT;

  typedef struct packed {
    statusT  status;
    payloadT data;
  } txFrameT;

endpackage

// File: source/sandbox_macros.svh
// Build-time sizes of the sandbox: payload bytes per frame and clocks per UART bit
// Included by the package and by every module that takes a default from it

`ifndef SANDBOX_MACROS_SVH
`define SANDBOX_MACROS_SVH

// Payload bytes in each request and reply frame
// One control or status byte precedes them on the line
`define SANDBOX_WIDTH 6

// masterClock cycles per UART bit
// 26 at 12 MHz gives roughly 460800 baud
`define SANDBOX_CLOCK_SCALE 26

`endif
